/* hdl/issue_pkg.sv */
`default_nettype none

package issue_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and basic types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  parameter int xlen = 32;

  // default number of buffer entries.
  parameter int buffer_depth = 8;

  typedef logic [xlen-1:0] word_t;
  typedef logic [2*xlen-1:0] fetch_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [1:0] {
    class_none,
    class_basic,
    class_complex
  } instr_class_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // rv32 opcode map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;
  localparam logic [6:0] opcode_system    = 7'b1110011;

  // alu funct3 codes.
  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  // alt selects sub and sra.
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // empty slot markers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // addi x0,x0,0.
  localparam word_t nop_instr = 32'h0000_0013;
  localparam word_t empty_pc  = 32'hffff_ffff;

endpackage

`default_nettype wire

/* hdl/fetch_buffer.sv */
`default_nettype none

module fetch_buffer #(
  parameter int depth = 8
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              clear,
  input  logic              fetch_ready,
  input  issue_pkg::word_t  fetch_pc,
  input  issue_pkg::fetch_t fetch_data,
  input  logic [1:0]        take,
  output issue_pkg::word_t  head_pc0,
  output issue_pkg::word_t  head_pc1,
  output issue_pkg::word_t  head_instr0,
  output issue_pkg::word_t  head_instr1,
  output logic              head_valid0,
  output logic              head_valid1,
  output logic              buffer_full
);

  import issue_pkg::*;

  localparam int ptr_w = $clog2(depth);
  localparam int half = depth / 2;

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0] count_t;

  word_t pc_mem [depth];
  word_t instr_mem [depth];

  ptr_t   wid;
  ptr_t   rid;
  ptr_t   wid_plus1;
  ptr_t   rid_plus1;
  count_t count;
  count_t count_next;
  logic   write_en;
  word_t  in_pc1;

  // full blocks the write in the same cycle.
  assign write_en   = fetch_ready && !buffer_full;
  assign in_pc1     = fetch_pc + word_t'(4);
  assign wid_plus1  = wid + ptr_t'(1);
  assign rid_plus1  = rid + ptr_t'(1);
  assign count_next = count + (write_en ? count_t'(2) : count_t'(0)) - count_t'(take);

  // head view, bypassing a word written this cycle.
  always_comb begin
    head_valid0 = 1'b0;
    head_pc0    = '0;
    head_instr0 = nop_instr;
    if (count != '0) begin
      head_valid0 = 1'b1;
      head_pc0    = pc_mem[rid];
      head_instr0 = instr_mem[rid];
    end else if (write_en) begin
      head_valid0 = 1'b1;
      head_pc0    = fetch_pc;
      head_instr0 = fetch_data[xlen-1:0];
    end
  end

  always_comb begin
    head_valid1 = 1'b0;
    head_pc1    = '0;
    head_instr1 = nop_instr;
    if (count > count_t'(1)) begin
      head_valid1 = 1'b1;
      head_pc1    = pc_mem[rid_plus1];
      head_instr1 = instr_mem[rid_plus1];
    end else if (write_en) begin
      head_valid1 = 1'b1;
      // one stored entry puts the new low half second.
      head_pc1    = (count == count_t'(1)) ? fetch_pc : in_pc1;
      head_instr1 = (count == count_t'(1)) ? fetch_data[xlen-1:0] : fetch_data[2*xlen-1:xlen];
    end
  end

  always_ff @(posedge clock) begin
    if (write_en && !clear) begin
      pc_mem[wid]          <= fetch_pc;
      instr_mem[wid]       <= fetch_data[xlen-1:0];
      pc_mem[wid_plus1]    <= in_pc1;
      instr_mem[wid_plus1] <= fetch_data[2*xlen-1:xlen];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wid         <= '0;
      rid         <= '0;
      count       <= '0;
      buffer_full <= 1'b0;
    end else begin
      if (write_en) begin
        wid <= wid + ptr_t'(2);
      end
      rid         <= rid + ptr_t'(take);
      count       <= count_next;
      buffer_full <= count_next > count_t'(half);
    end
  end

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
`default_nettype none

module instr_decode (
  input  issue_pkg::word_t        instr,
  output issue_pkg::instr_class_t instr_class,
  output logic                    wren,
  output logic                    rden1,
  output logic                    rden2,
  output issue_pkg::reg_addr_t    waddr,
  output issue_pkg::reg_addr_t    raddr1,
  output issue_pkg::reg_addr_t    raddr2
);

  import issue_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       writes;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign waddr  = instr[11:7];
  assign raddr1 = instr[19:15];
  assign raddr2 = instr[24:20];

  // x0 is never a real destination.
  assign wren = writes && (waddr != '0);

  always_comb begin
    instr_class = class_none;
    writes      = 1'b0;
    rden1       = 1'b0;
    rden2       = 1'b0;
    case (opcode)
      opcode_lui, opcode_auipc, opcode_jal: begin
        instr_class = class_basic;
        writes      = 1'b1;
      end
      opcode_jalr: begin
        instr_class = class_basic;
        writes      = 1'b1;
        rden1       = 1'b1;
      end
      opcode_branch: begin
        instr_class = class_basic;
        rden1       = 1'b1;
        rden2       = 1'b1;
      end
      opcode_load: begin
        instr_class = class_complex;
        writes      = 1'b1;
        rden1       = 1'b1;
      end
      opcode_store: begin
        instr_class = class_complex;
        rden1       = 1'b1;
        rden2       = 1'b1;
      end
      opcode_immediate: begin
        writes = 1'b1;
        rden1  = 1'b1;
        case (funct3)
          funct_sll: begin
            instr_class = (funct7 == funct7_base) ? class_basic : class_complex;
          end
          funct_srl: begin
            if (funct7 == funct7_base || funct7 == funct7_alt) begin
              instr_class = class_basic;
            end else begin
              instr_class = class_complex;
            end
          end
          default: begin
            instr_class = class_basic;
          end
        endcase
      end
      opcode_register: begin
        writes = 1'b1;
        rden1  = 1'b1;
        rden2  = 1'b1;
        if (funct7 == funct7_base) begin
          instr_class = class_basic;
        end else if (funct7 == funct7_alt &&
                     (funct3 == funct_add || funct3 == funct_srl)) begin
          // sub and sra.
          instr_class = class_basic;
        end else begin
          // m extension lands here.
          instr_class = class_complex;
        end
      end
      opcode_fence: begin
        instr_class = class_complex;
      end
      opcode_system: begin
        instr_class = class_complex;
        writes      = (funct3 != 3'd0);
        // csr forms with a register source.
        rden1       = (funct3 == 3'd1) || (funct3 == 3'd2) || (funct3 == 3'd3);
      end
      default: begin
        instr_class = class_none;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/issue_select.sv */
`default_nettype none

module issue_select (
  input  logic                    issue_stall,
  input  logic                    valid0,
  input  logic                    valid1,
  input  issue_pkg::word_t        pc_in0,
  input  issue_pkg::word_t        pc_in1,
  input  issue_pkg::word_t        instr_in0,
  input  issue_pkg::word_t        instr_in1,
  input  issue_pkg::instr_class_t class0,
  input  issue_pkg::instr_class_t class1,
  input  logic                    wren0,
  input  logic                    rden1_1,
  input  logic                    rden2_1,
  input  issue_pkg::reg_addr_t    waddr0,
  input  issue_pkg::reg_addr_t    raddr1_1,
  input  issue_pkg::reg_addr_t    raddr2_1,
  output logic [1:0]              take,
  output issue_pkg::word_t        pc0,
  output issue_pkg::word_t        pc1,
  output issue_pkg::word_t        npc0,
  output issue_pkg::word_t        npc1,
  output issue_pkg::word_t        instr0,
  output issue_pkg::word_t        instr1,
  output logic                    swap
);

  import issue_pkg::*;

  logic  raw_hit;
  logic  pair_ok;
  word_t npc_in0;
  word_t npc_in1;

  // slot 1 reads what slot 0 writes.
  assign raw_hit = wren0 && ((rden1_1 && raddr1_1 == waddr0) ||
                             (rden2_1 && raddr2_1 == waddr0));

  assign pair_ok = !(class0 == class_complex && class1 == class_complex) && !raw_hit;

  always_comb begin
    if (issue_stall || !valid0) begin
      take = 2'd0;
    end else if (valid1 && pair_ok) begin
      take = 2'd2;
    end else begin
      take = 2'd1;
    end
  end

  // complex op always leaves on slot 0.
  assign swap = (take == 2'd2) && class0 == class_basic && class1 == class_complex;

  // compressed encodings step by 2.
  assign npc_in0 = pc_in0 + ((instr_in0[1:0] == 2'b11) ? word_t'(4) : word_t'(2));
  assign npc_in1 = pc_in1 + ((instr_in1[1:0] == 2'b11) ? word_t'(4) : word_t'(2));

  assign pc0    = (take == 2'd0) ? empty_pc : (swap ? pc_in1 : pc_in0);
  assign npc0   = (take == 2'd0) ? empty_pc : (swap ? npc_in1 : npc_in0);
  assign instr0 = (take == 2'd0) ? nop_instr : (swap ? instr_in1 : instr_in0);

  assign pc1    = (take != 2'd2) ? empty_pc : (swap ? pc_in0 : pc_in1);
  assign npc1   = (take != 2'd2) ? empty_pc : (swap ? npc_in0 : npc_in1);
  assign instr1 = (take != 2'd2) ? nop_instr : (swap ? instr_in0 : instr_in1);

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
`default_nettype none

module issue_stage #(
  parameter int buffer_depth = issue_pkg::buffer_depth
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              clear,
  input  logic              fetch_ready,
  input  issue_pkg::word_t  fetch_pc,
  input  issue_pkg::fetch_t fetch_data,
  input  logic              issue_stall,
  output issue_pkg::word_t  pc0,
  output issue_pkg::word_t  pc1,
  output issue_pkg::word_t  npc0,
  output issue_pkg::word_t  npc1,
  output issue_pkg::word_t  instr0,
  output issue_pkg::word_t  instr1,
  output logic              swap,
  output logic              buffer_full
);

  import issue_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // head pair of the buffer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [1:0] take;
  word_t      head_pc0;
  word_t      head_pc1;
  word_t      head_instr0;
  word_t      head_instr1;
  logic       head_valid0;
  logic       head_valid1;

  fetch_buffer #(
    .depth(buffer_depth)
  ) buffer (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch_ready(fetch_ready),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .take(take),
    .head_pc0(head_pc0),
    .head_pc1(head_pc1),
    .head_instr0(head_instr0),
    .head_instr1(head_instr1),
    .head_valid0(head_valid0),
    .head_valid1(head_valid1),
    .buffer_full(buffer_full)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per slot decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  instr_class_t class0;
  instr_class_t class1;
  logic         wren0;
  logic         rden1_1;
  logic         rden2_1;
  reg_addr_t    waddr0;
  reg_addr_t    raddr1_1;
  reg_addr_t    raddr2_1;

  // slot 0 only matters as a writer.
  instr_decode decode0 (
    .instr(head_instr0),
    .instr_class(class0),
    .wren(wren0),
    .rden1(),
    .rden2(),
    .waddr(waddr0),
    .raddr1(),
    .raddr2()
  );

  // slot 1 only matters as a reader.
  instr_decode decode1 (
    .instr(head_instr1),
    .instr_class(class1),
    .wren(),
    .rden1(rden1_1),
    .rden2(rden2_1),
    .waddr(),
    .raddr1(raddr1_1),
    .raddr2(raddr2_1)
  );

  issue_select select (
    .issue_stall(issue_stall),
    .valid0(head_valid0),
    .valid1(head_valid1),
    .pc_in0(head_pc0),
    .pc_in1(head_pc1),
    .instr_in0(head_instr0),
    .instr_in1(head_instr1),
    .class0(class0),
    .class1(class1),
    .wren0(wren0),
    .rden1_1(rden1_1),
    .rden2_1(rden2_1),
    .waddr0(waddr0),
    .raddr1_1(raddr1_1),
    .raddr2_1(raddr2_1),
    .take(take),
    .pc0(pc0),
    .pc1(pc1),
    .npc0(npc0),
    .npc1(npc1),
    .instr0(instr0),
    .instr1(instr1),
    .swap(swap)
  );

endmodule

`default_nettype wire

/* tests/issue_stage_asserts.sv */
`default_nettype none

module issue_stage_asserts (
  input logic             clock,
  input logic             reset,
  input logic             clear,
  input logic             fetch_ready,
  input logic             issue_stall,
  input issue_pkg::word_t pc0,
  input issue_pkg::word_t pc1,
  input issue_pkg::word_t instr0,
  input issue_pkg::word_t instr1,
  input logic             swap,
  input logic             buffer_full
);

  timeunit 1ns;
  timeprecision 1ps;

  import issue_pkg::*;

  reset_clears_full: assert property (@(posedge clock) !reset |=> !buffer_full)
    else $error("buffer_full still high after reset");

  // a swap always moves a real pair.
  swap_has_pair: assert property (@(posedge clock) disable iff (!reset)
    swap |-> pc1 != empty_pc)
    else $error("swap raised with an empty slot 1");

  slots_fill_in_order: assert property (@(posedge clock) disable iff (!reset)
    pc0 == empty_pc |-> pc1 == empty_pc)
    else $error("slot 1 issued while slot 0 is empty");

  // nothing moves while stalled with no fetch.
  stall_holds_outputs: assert property (@(posedge clock) disable iff (!reset)
    $past(issue_stall && !fetch_ready && !clear) && issue_stall
      |-> $stable(pc0) && $stable(pc1) && $stable(instr0) && $stable(instr1)
          && $stable(swap) && $stable(buffer_full))
    else $error("outputs changed under a held stall");

endmodule

bind issue_stage issue_stage_asserts asserts (
  .clock(clock),
  .reset(reset),
  .clear(clear),
  .fetch_ready(fetch_ready),
  .issue_stall(issue_stall),
  .pc0(pc0),
  .pc1(pc1),
  .instr0(instr0),
  .instr1(instr1),
  .swap(swap),
  .buffer_full(buffer_full)
);

`default_nettype wire

/* tests/issue_stage_tb.sv */
`default_nettype none

module issue_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import issue_pkg::*;

  localparam int depth = 8;
  // reset plus every test, in clock cycles.
  localparam int test_cycles = 40;

  logic   clock;
  logic   reset;
  logic   clear;
  logic   fetch_ready;
  word_t  fetch_pc;
  fetch_t fetch_data;
  logic   issue_stall;
  word_t  pc0;
  word_t  pc1;
  word_t  npc0;
  word_t  npc1;
  word_t  instr0;
  word_t  instr1;
  logic   swap;
  logic   buffer_full;

  // model of the buffer contents.
  word_t       q_pc[$];
  word_t       q_ins[$];
  logic        model_full;
  int          errors;
  int          err_mark;
  int          checks;
  int          tests;
  logic [31:0] lcg_state = 32'h729e_8840;

  issue_stage #(
    .buffer_depth(depth)
  ) UUT (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch_ready(fetch_ready),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .issue_stall(issue_stall),
    .pc0(pc0),
    .pc1(pc1),
    .npc0(npc0),
    .npc1(npc1),
    .instr0(instr0),
    .instr1(instr1),
    .swap(swap),
    .buffer_full(buffer_full)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #(test_cycles * 4 * 10);
    $display("watchdog: run did not finish within %0d cycles", test_cycles * 4);
    $display("=== FAIL ===");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encoders and reference rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, funct_add, rd, opcode_immediate};
  endfunction

  function automatic word_t add_rr(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return {funct7_base, rs2, rs1, funct_add, rd, opcode_register};
  endfunction

  function automatic word_t lw(reg_addr_t rd, reg_addr_t rs1);
    return {12'd0, rs1, 3'b010, rd, opcode_load};
  endfunction

  function automatic word_t sw(reg_addr_t rs2, reg_addr_t rs1);
    return {7'd0, rs2, rs1, 3'b010, 5'd0, opcode_store};
  endfunction

  function automatic instr_class_t classify(word_t i);
    logic [6:0] f7;
    f7 = i[31:25];
    case (i[6:0])
      opcode_lui, opcode_auipc, opcode_jal, opcode_jalr, opcode_branch: return class_basic;
      opcode_load, opcode_store, opcode_fence, opcode_system: return class_complex;
      opcode_immediate: begin
        // only the shifts care about funct7.
        if (i[13:12] != 2'b01 || f7 == funct7_base || (i[14] && f7 == funct7_alt)) begin
          return class_basic;
        end
        return class_complex;
      end
      opcode_register: begin
        if (f7 == funct7_base || (f7 == funct7_alt &&
            (i[14:12] == funct_add || i[14:12] == funct_srl))) begin
          return class_basic;
        end
        return class_complex;
      end
      default: return class_none;
    endcase
  endfunction

  function automatic logic raw_hazard(word_t a, word_t b);
    logic writes;
    logic reads1;
    logic reads2;
    writes = a[6:0] inside {opcode_lui, opcode_auipc, opcode_jal, opcode_jalr, opcode_load,
                            opcode_immediate, opcode_register} ||
             (a[6:0] == opcode_system && a[14:12] != 3'd0);
    reads1 = b[6:0] inside {opcode_jalr, opcode_branch, opcode_load, opcode_store,
                            opcode_immediate, opcode_register} ||
             (b[6:0] == opcode_system && b[14:12] inside {3'd1, 3'd2, 3'd3});
    reads2 = b[6:0] inside {opcode_branch, opcode_store, opcode_register};
    return writes && a[11:7] != 5'd0 &&
           ((reads1 && b[19:15] == a[11:7]) || (reads2 && b[24:20] == a[11:7]));
  endfunction

  function automatic word_t next_pc(word_t pc, word_t i);
    return pc + ((i[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cycle driver and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare(string name, word_t got, word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_cycle(logic rdy, word_t pc, fetch_t data, logic stall, logic clr);
    int    take;
    int    k;
    int    s;
    logic  e_swap;
    word_t e_pc[2];
    word_t e_npc[2];
    word_t e_ins[2];
    @(posedge clock);
    fetch_ready <= rdy;
    fetch_pc    <= pc;
    fetch_data  <= data;
    issue_stall <= stall;
    clear       <= clr;
    if (rdy && !model_full) begin
      q_pc.push_back(pc);
      q_ins.push_back(data[31:0]);
      q_pc.push_back(pc + 32'd4);
      q_ins.push_back(data[63:32]);
    end
    take = 0;
    e_swap = 1'b0;
    if (!stall && q_pc.size() > 0) begin
      take = 1;
      if (q_pc.size() > 1) begin
        if (!(classify(q_ins[0]) == class_complex && classify(q_ins[1]) == class_complex)
            && !raw_hazard(q_ins[0], q_ins[1])) begin
          take = 2;
          e_swap = classify(q_ins[0]) == class_basic && classify(q_ins[1]) == class_complex;
        end
      end
    end
    for (k = 0; k < 2; k++) begin
      e_pc[k]  = empty_pc;
      e_npc[k] = empty_pc;
      e_ins[k] = nop_instr;
      if (k < take) begin
        s = e_swap ? 1 - k : k;
        e_pc[k]  = q_pc[s];
        e_npc[k] = next_pc(q_pc[s], q_ins[s]);
        e_ins[k] = q_ins[s];
      end
    end
    @(negedge clock);
    compare("pc0", pc0, e_pc[0]);
    compare("pc1", pc1, e_pc[1]);
    compare("npc0", npc0, e_npc[0]);
    compare("npc1", npc1, e_npc[1]);
    compare("instr0", instr0, e_ins[0]);
    compare("instr1", instr1, e_ins[1]);
    compare("swap", {31'd0, swap}, {31'd0, e_swap});
    compare("buffer_full", {31'd0, buffer_full}, {31'd0, model_full});
    repeat (take) begin
      void'(q_pc.pop_front());
      void'(q_ins.pop_front());
    end
    if (clr) begin
      q_pc.delete();
      q_ins.delete();
    end
    model_full = q_pc.size() > depth / 2;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic finish_test(string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic empty_after_reset();
    idle_cycles(2);
    finish_test("reset and empty");
  endtask

  task automatic dual_issue_next_pc();
    drive_cycle(1'b1, 32'h100, {addi(5'd2, 5'd0, 12'd7), addi(5'd1, 5'd0, 12'd5)}, 1'b0, 1'b0);
    // low half is a compressed c.li.
    drive_cycle(1'b1, 32'h108, {addi(5'd3, 5'd0, 12'd1), 32'h0000_4501}, 1'b0, 1'b0);
    idle_cycles(1);
    finish_test("dual issue and next pc");
  endtask

  task automatic hazard_splits_pair();
    logic [31:0] r;
    reg_addr_t   rd;
    r = lcg_next();
    rd = 5'd1 + (r[20:16] % 5'd31);
    drive_cycle(1'b1, 32'h200, {add_rr(5'd5, rd, 5'd0), addi(rd, 5'd0, 12'd1)}, 1'b0, 1'b0);
    idle_cycles(1);
    drive_cycle(1'b1, 32'h208, {add_rr(5'd5, 5'd0, 5'd0), addi(5'd0, 5'd0, 12'd1)},
                1'b0, 1'b0);
    idle_cycles(1);
    finish_test("raw hazard");
  endtask

  task automatic swap_and_complex();
    drive_cycle(1'b1, 32'h300, {lw(5'd2, 5'd3), addi(5'd1, 5'd0, 12'd1)}, 1'b0, 1'b0);
    drive_cycle(1'b1, 32'h308, {sw(5'd4, 5'd5), lw(5'd2, 5'd3)}, 1'b0, 1'b0);
    idle_cycles(2);
    finish_test("swap and complex pairing");
  endtask

  task automatic backpressure_and_clear();
    int k;
    int dropped;
    dropped = 0;
    for (k = 0; k < 6; k++) begin
      drive_cycle(1'b1, word_t'(32'h400 + 8 * k),
                  {addi(reg_addr_t'(2 * k + 2), 5'd0, 12'd1),
                   addi(reg_addr_t'(2 * k + 1), 5'd0, 12'd1)}, 1'b1, 1'b0);
      // the word offered in this cycle was refused.
      if (buffer_full) begin
        dropped++;
      end
    end
    assert (dropped > 0) else begin
      $display("backpressure: no fetch word was refused while the buffer was full");
      errors++;
    end
    // hold the stall with nothing offered.
    repeat (2) drive_cycle(1'b0, '0, '0, 1'b1, 1'b0);
    idle_cycles(4);
    drive_cycle(1'b1, 32'h500, {addi(5'd2, 5'd0, 12'd3), addi(5'd1, 5'd0, 12'd3)}, 1'b1, 1'b0);
    drive_cycle(1'b1, 32'h508, {addi(5'd4, 5'd0, 12'd3), addi(5'd3, 5'd0, 12'd3)}, 1'b1, 1'b0);
    // second word is still queued when the clear lands.
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1);
    idle_cycles(1);
    finish_test("back-pressure and clear");
  endtask

  initial begin
    reset       = 1'b0;
    clear       = 1'b0;
    fetch_ready = 1'b0;
    fetch_pc    = '0;
    fetch_data  = '0;
    issue_stall = 1'b0;
    model_full  = 1'b0;
    errors      = 0;
    err_mark    = 0;
    checks      = 0;
    tests       = 0;
    repeat (10) @(posedge clock);
    reset <= 1'b1;
    empty_after_reset();
    dual_issue_next_pc();
    hazard_splits_pair();
    swap_and_complex();
    backpressure_and_clear();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/issue_pkg.sv
hdl/fetch_buffer.sv
hdl/instr_decode.sv
hdl/issue_select.sv
hdl/issue_stage.sv
tests/issue_stage_asserts.sv
tests/issue_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module issue_stage_tb -f verilog.f \
  -o issue_stage_sim \
  && ./obj_dir/issue_stage_sim > sim.log 2>&1 \
  || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0
